// File: sd_pkg.sv
/*
 * Shared definitions for the SD host DAT path
 * Widths, FIFO depth, Wishbone register map, DAT state encoding
 * and the structs passed between the register block and the PHY
 */
package sd_pkg;

   localparam int word_w       = 32;   // FIFO and bus word
   localparam int nib_per_word = 8;
   localparam int blk_sz_w     = 10;   // Byte count, up to 512
   localparam int blk_cnt_w    = 16;
   localparam int fifo_depth   = 128;  // One maximum block
   localparam int fifo_lvl_w   = 8;
   localparam int crc_nibbles  = 16;

   // Word addresses on the Wishbone side
   typedef enum logic [2:0] {
      reg_ctrl   = 3'd0,
      reg_blksz  = 3'd1,
      reg_blkcnt = 3'd2,
      reg_status = 3'd3,
      reg_data   = 3'd4
   } wb_adr_e;

   typedef enum logic [3:0] {
      idle,
      wr_wait_fifo,
      wr_start,
      wr_data,
      wr_crc,
      wr_end,
      wr_busy,
      rd_wait_start,
      rd_data,
      rd_crc,
      rd_end
   } dat_state_e;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [2:0]        adr;
      logic [word_w-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [word_w-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic [blk_sz_w-1:0]  blk_sz;
      logic [blk_cnt_w-1:0] blk_cnt;
   } xfer_cfg_t;

   // Last member is the LSB, so busy lands on status bit 0
   typedef struct packed {
      logic card_busy;
      logic overflow;
      logic crc_err;
      logic done;
      logic busy;
   } phys_stat_t;

endpackage

// File: sd_crc16.sv
/*
 * CRC-16 CCITT for the four DAT lines
 * One 16-bit register per line, x^16+x^12+x^5+1, seed 0
 */
module sd_crc16 (
   input  logic        sd_clk,
   input  logic        rst_L,
   input  logic        clear,
   input  logic        en,
   input  logic [3:0]  din,
   output logic [63:0] crc       // Line k in bits 16k+15:16k
);

   always_ff @(posedge sd_clk) begin
      if (!rst_L || clear) begin
         crc <= '0;
      end else if (en) begin
         for (int k = 0; k < 4; k++) begin
            // Feedback is the incoming bit against the register MSB
            crc[16*k +: 16] <= {crc[16*k +: 15], 1'b0} ^
                               ((din[k] ^ crc[16*k+15]) ? 16'h1021 : 16'h0000);
         end
      end
   end

endmodule

// File: sd_fifo.sv
/*
 * Synchronous word FIFO, first word falls through
 * Circular buffer with level, full and empty
 */
module sd_fifo #(
   parameter int depth = sd_pkg::fifo_depth
) (
   input  logic                          sd_clk,
   input  logic                          rst_L,
   input  logic                          push,
   input  logic [sd_pkg::word_w-1:0]     wr_data,
   input  logic                          pop,
   output logic [sd_pkg::word_w-1:0]     rd_data,
   output logic [sd_pkg::fifo_lvl_w-1:0] level,
   output logic                          full,
   output logic                          empty
);
   import sd_pkg::*;

   logic [word_w-1:0]        mem [depth];
   logic [$clog2(depth)-1:0] wr_ptr;
   logic [$clog2(depth)-1:0] rd_ptr;
   logic                     do_push;
   logic                     do_pop;

   assign full    = (int'(level) == depth);
   assign empty   = (level == '0);
   assign do_push = push && !full;   // Push on full is dropped
   assign do_pop  = pop && !empty;
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge sd_clk) begin
      if (do_push) mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_push) wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;     // Both or neither
         endcase
      end
   end

endmodule

// File: sd_dat_phys.sv
/*
 * DAT line physical layer, 4-bit bus
 * Block write with CRC and card busy wait, block read with CRC check
 */
module sd_dat_phys (
   input  logic                          sd_clk,
   input  logic                          rst_L,
   input  logic                          start_wr,
   input  logic                          start_rd,
   input  sd_pkg::xfer_cfg_t             cfg,
   output sd_pkg::phys_stat_t            stat,
   input  logic [sd_pkg::word_w-1:0]     tx_data,
   input  logic [sd_pkg::fifo_lvl_w-1:0] tx_level,
   output logic                          tx_pop,
   output logic [sd_pkg::word_w-1:0]     rx_data,
   output logic                          rx_push,
   input  logic                          rx_full,
   input  logic [3:0]                    dat_in,
   output logic [3:0]                    dat_out,
   output logic                          dat_oe
);
   import sd_pkg::*;

   dat_state_e                      state;
   logic [$clog2(nib_per_word)-1:0] nib_off;
   logic [blk_sz_w-1:0]             byte_rem;
   logic [blk_cnt_w-1:0]            blk_rem;
   logic [3:0]                      crc_cnt;
   logic [word_w-1:0]               shreg;
   logic                            word_rdy;  // Read word complete, push now
   logic                            done;
   logic                            crc_err;
   logic                            overflow;

   logic        lvl_ok;
   logic        wr_load;
   logic        word_end;
   logic        last_word;
   logic        crc_clr;
   logic        crc_en;
   logic [3:0]  crc_din;
   logic [3:0]  crc_nib;
   logic [63:0] crc_all;

   ////////////////////////////////////////////////////////////////////////////
   // Datapath decode

   always_comb begin
      lvl_ok    = (tx_level >= cfg.blk_sz[blk_sz_w-1:2]);  // Whole block ready
      wr_load   = (state == wr_start) || (state == wr_data && byte_rem != '0);
      word_end  = (nib_off == 3'(nib_per_word - 1));
      last_word = (byte_rem == blk_sz_w'(4));
      tx_pop    = (state == wr_wait_fifo && lvl_ok) || (wr_load && word_end && !last_word);
      crc_clr   = (state == wr_wait_fifo && lvl_ok) ||
                  (state == rd_wait_start && dat_in == 4'h0);
      crc_en    = wr_load || (state == rd_data);
      crc_din   = (state == rd_data) ? dat_in : shreg[word_w-1 -: 4];
      for (int k = 0; k < 4; k++) begin
         crc_nib[k] = crc_all[16*k + 15 - int'(crc_cnt)];  // MSB first per line
      end
   end

   always_comb begin
      stat.busy      = (state != idle);
      stat.done      = done;
      stat.crc_err   = crc_err;
      stat.overflow  = overflow;
      stat.card_busy = (state == wr_busy) && !dat_in[0];
   end

   assign rx_data = shreg;     // Holds the finished word in the push cycle
   assign rx_push = word_rdy;

   sd_crc16 crc16 (
      .sd_clk (sd_clk),
      .rst_L  (rst_L),
      .clear  (crc_clr),
      .en     (crc_en),
      .din    (crc_din),
      .crc    (crc_all)
   );

   always_ff @(posedge sd_clk) begin
      if (tx_pop) shreg <= tx_data;
      else if (wr_load) shreg <= {shreg[word_w-5:0], 4'h0};
      else if (state == rd_data) shreg <= {shreg[word_w-5:0], dat_in};
   end

   ////////////////////////////////////////////////////////////////////////////
   // State machine, state names what is currently on the lines

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state    <= idle;
         nib_off  <= '0;
         byte_rem <= '0;
         blk_rem  <= '0;
         crc_cnt  <= '0;
         word_rdy <= 1'b0;
         done     <= 1'b0;
         crc_err  <= 1'b0;
         overflow <= 1'b0;
         dat_out  <= '0;
         dat_oe   <= 1'b0;
      end else begin
         word_rdy <= 1'b0;
         if (word_rdy && rx_full) overflow <= 1'b1;  // FIFO drops this word
         case (state)
            idle: begin
               if (start_wr || start_rd) begin
                  blk_rem  <= cfg.blk_cnt;
                  done     <= 1'b0;
                  crc_err  <= 1'b0;
                  overflow <= 1'b0;
                  state    <= start_wr ? wr_wait_fifo : rd_wait_start;
               end
            end
            wr_wait_fifo: begin
               if (lvl_ok) begin
                  dat_out  <= 4'h0;          // Start nibble
                  dat_oe   <= 1'b1;
                  nib_off  <= '0;
                  byte_rem <= cfg.blk_sz;
                  crc_cnt  <= '0;
                  state    <= wr_start;
               end
            end
            wr_start, wr_data: begin
               if (wr_load) begin
                  dat_out <= shreg[word_w-1 -: 4];
                  state   <= wr_data;
                  if (word_end) begin
                     nib_off  <= '0;
                     byte_rem <= byte_rem - blk_sz_w'(4);
                  end else begin
                     nib_off <= nib_off + 1'b1;
                  end
               end else begin
                  dat_out <= crc_nib;        // First CRC nibble
                  crc_cnt <= crc_cnt + 1'b1;
                  state   <= wr_crc;
               end
            end
            wr_crc: begin
               // Counter wraps to 0 once all 16 nibbles are out
               if (crc_cnt == '0) begin
                  dat_out <= 4'hF;
                  state   <= wr_end;
               end else begin
                  dat_out <= crc_nib;
                  crc_cnt <= crc_cnt + 1'b1;
               end
            end
            wr_end: begin
               dat_out <= 4'h0;
               dat_oe  <= 1'b0;
               state   <= wr_busy;
            end
            wr_busy: begin
               // First cycle always waits, gives the card time to pull DAT0
               if (crc_cnt == '0) begin
                  crc_cnt <= 4'd1;
               end else if (dat_in[0]) begin
                  blk_rem <= blk_rem - 1'b1;
                  if (blk_rem == blk_cnt_w'(1)) begin
                     done  <= 1'b1;
                     state <= idle;
                  end else begin
                     state <= wr_wait_fifo;
                  end
               end
            end
            rd_wait_start: begin
               if (dat_in == 4'h0) begin
                  nib_off  <= '0;
                  byte_rem <= cfg.blk_sz;
                  crc_cnt  <= '0;
                  state    <= rd_data;
               end
            end
            rd_data: begin
               if (word_end) begin
                  nib_off  <= '0;
                  word_rdy <= 1'b1;
                  byte_rem <= byte_rem - blk_sz_w'(4);
                  if (last_word) state <= rd_crc;
               end else begin
                  nib_off <= nib_off + 1'b1;
               end
            end
            rd_crc: begin
               if (dat_in != crc_nib) crc_err <= 1'b1;
               crc_cnt <= crc_cnt + 1'b1;
               if (crc_cnt == 4'(crc_nibbles - 1)) state <= rd_end;
            end
            rd_end: begin
               if (dat_in != 4'hF) crc_err <= 1'b1;   // Bad end nibble
               blk_rem <= blk_rem - 1'b1;
               if (blk_rem == blk_cnt_w'(1)) begin
                  done  <= 1'b1;
                  state <= idle;
               end else begin
                  state <= rd_wait_start;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

// File: sd_wb_regs.sv
/*
 * Wishbone classic register block
 * Control, block size, block count, status and the FIFO data port
 */
module sd_wb_regs (
   input  logic                      sd_clk,
   input  logic                      rst_L,
   input  sd_pkg::wb_req_t           wb_req,
   output sd_pkg::wb_rsp_t           wb_rsp,
   output sd_pkg::xfer_cfg_t         cfg,
   output logic                      start_wr,
   output logic                      start_rd,
   input  sd_pkg::phys_stat_t        stat,
   output logic                      tx_push,
   output logic [sd_pkg::word_w-1:0] tx_wdata,
   input  logic                      tx_full,
   output logic                      rx_pop,
   input  logic [sd_pkg::word_w-1:0] rx_rdata,
   input  logic                      rx_empty
);
   import sd_pkg::*;

   wb_adr_e           adr;
   logic              req_q;      // Request seen last cycle
   logic              new_req;
   logic              wr_acc;
   logic              rd_acc;
   logic              ack_q;
   logic [word_w-1:0] rdat_q;
   logic [word_w-1:0] rd_mux;

   assign adr     = wb_adr_e'(wb_req.adr);
   assign new_req = wb_req.cyc && wb_req.stb && !req_q;
   assign wr_acc  = new_req && wb_req.we;
   assign rd_acc  = new_req && !wb_req.we;
   assign wb_rsp  = '{ack: ack_q, dat: rdat_q};

   always_comb begin
      case (adr)
         reg_blksz:  rd_mux = word_w'(cfg.blk_sz);
         reg_blkcnt: rd_mux = word_w'(cfg.blk_cnt);
         reg_status: rd_mux = word_w'(stat);
         reg_data:   rd_mux = rx_empty ? '0 : rx_rdata;
         default:    rd_mux = '0;                     // Ctrl and holes
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control registers and one-cycle pulses, all land in the ack cycle

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         req_q    <= 1'b0;
         ack_q    <= 1'b0;
         start_wr <= 1'b0;
         start_rd <= 1'b0;
         tx_push  <= 1'b0;
         rx_pop   <= 1'b0;
         cfg      <= '0;
      end else begin
         req_q    <= wb_req.cyc && wb_req.stb;  // No new ack until stb drops
         ack_q    <= new_req;
         start_wr <= wr_acc && adr == reg_ctrl && wb_req.dat[1:0] == 2'b01 && !stat.busy;
         start_rd <= wr_acc && adr == reg_ctrl && wb_req.dat[1:0] == 2'b10 && !stat.busy;
         tx_push  <= wr_acc && adr == reg_data && !tx_full;
         rx_pop   <= rd_acc && adr == reg_data && !rx_empty;
         if (wr_acc && adr == reg_blksz)  cfg.blk_sz  <= wb_req.dat[blk_sz_w-1:0];
         if (wr_acc && adr == reg_blkcnt) cfg.blk_cnt <= wb_req.dat[blk_cnt_w-1:0];
      end
   end

   always_ff @(posedge sd_clk) begin
      if (new_req) rdat_q <= rd_mux;
      if (wr_acc) tx_wdata <= wb_req.dat;
   end

endmodule

// File: sd_dat_top.sv
/*
 * SD host DAT path top level
 * Register block, transmit and receive FIFOs, DAT PHY
 */
module sd_dat_top (
   input  logic            sd_clk,
   input  logic            rst_L,
   input  sd_pkg::wb_req_t wb_req,
   output sd_pkg::wb_rsp_t wb_rsp,
   input  logic [3:0]      dat_in,
   output logic [3:0]      dat_out,
   output logic            dat_oe
);
   import sd_pkg::*;

   xfer_cfg_t             cfg;
   phys_stat_t            stat;
   logic                  start_wr;
   logic                  start_rd;
   logic                  tx_push;
   logic                  tx_pop;
   logic                  tx_full;
   logic [word_w-1:0]     tx_wdata;
   logic [word_w-1:0]     tx_rdata;
   logic [fifo_lvl_w-1:0] tx_level;
   logic                  rx_push;
   logic                  rx_pop;
   logic                  rx_full;
   logic                  rx_empty;
   logic [word_w-1:0]     rx_wdata;
   logic [word_w-1:0]     rx_rdata;

   sd_wb_regs regs (
      .sd_clk, .rst_L, .wb_req, .wb_rsp, .cfg, .start_wr, .start_rd, .stat,
      .tx_push, .tx_wdata, .tx_full, .rx_pop, .rx_rdata, .rx_empty
   );

   sd_fifo tx_fifo (
      .sd_clk, .rst_L, .push(tx_push), .wr_data(tx_wdata), .pop(tx_pop),
      .rd_data(tx_rdata), .level(tx_level), .full(tx_full), .empty()
   );

   sd_fifo rx_fifo (
      .sd_clk, .rst_L, .push(rx_push), .wr_data(rx_wdata), .pop(rx_pop),
      .rd_data(rx_rdata), .level(), .full(rx_full), .empty(rx_empty)
   );

   sd_dat_phys phys (
      .sd_clk, .rst_L, .start_wr, .start_rd, .cfg, .stat,
      .tx_data(tx_rdata), .tx_level, .tx_pop,
      .rx_data(rx_wdata), .rx_push, .rx_full,
      .dat_in, .dat_out, .dat_oe
   );

endmodule

// File: tb_sd_dat.sv
/*
 * Testbench for the SD host DAT path
 * Clock, watchdog, Wishbone tasks, card model, CRC-16 model
 * and directed write, busy, read, CRC error and overflow tests
 */
module tb_sd_dat;
   timeunit 1ns;
   timeprecision 100ps;
   import sd_pkg::*;

   // Status bits, busy is bit 0
   localparam logic [31:0] st_busy      = 32'h01;
   localparam logic [31:0] st_done      = 32'h02;
   localparam logic [31:0] st_crc_err   = 32'h04;
   localparam logic [31:0] st_overflow  = 32'h08;
   localparam logic [31:0] st_card_busy = 32'h10;

   // Frames of 16, 8 and 512 byte blocks over all tests
   localparam int frame_cycles = 3 * (2 + 16*2 + 16) + 3 * (2 + 8*2 + 16) +
                                 2 * (2 + 512*2 + 16);
   localparam int wd_cycles    = 3 * frame_cycles + 2000;

   logic       sd_clk;
   logic       rst_L;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic [3:0] dat_in;
   logic [3:0] dat_out;
   logic       dat_oe;

   logic [31:0] tx_words [256];
   logic [31:0] rx_words [256];
   logic [31:0] lfsr;
   logic [3:0]  cap_q [$];     // Nibbles seen on dat_out
   logic [3:0]  exp_q [$];
   string       cur_test;
   int          err_cnt;
   int          test_errs;
   int          tests_run;
   int          tests_failed;

   sd_dat_top dut (
      .sd_clk, .rst_L, .wb_req, .wb_rsp, .dat_in, .dat_out, .dat_oe
   );

   initial begin
      sd_clk = 1'b0;
      forever #50 sd_clk = ~sd_clk;
   end

   initial begin
      repeat (wd_cycles) @(posedge sd_clk);
      $display("Timeout: the tests did not complete within %0d cycles", wd_cycles);
      $display("Finished with errors");
      $finish;
   end

   ///////////////////////////////////////////////////////////////////////////
   // Bookkeeping and models

   task automatic note_error();
      err_cnt++;
      test_errs++;
   endtask

   task automatic check_val(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, exp, act);
         note_error();
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
      tests_run++;
   endtask

   task automatic end_test();
      if (test_errs == 0) begin
         $display("Test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("Test %s: %0d mismatches", cur_test, test_errs);
      end
   endtask

   // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit
   function automatic logic [31:0] next_word();
      logic [31:0] w;
      int          i;
      w = '0;
      for (i = 0; i < 32; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         w    = {w[30:0], lfsr[0]};
      end
      return w;
   endfunction

   // CCITT serial step, seed 0
   function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic bit_in);
      return {crc[14:0], 1'b0} ^ ((bit_in ^ crc[15]) ? 16'h1021 : 16'h0000);
   endfunction

   task automatic wb_access(input logic we, input logic [2:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int n;
      @(posedge sd_clk);
      #10;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      n = 0;
      do begin
         @(negedge sd_clk);
         n++;
      end while (wb_rsp.ack !== 1'b1 && n < 20);
      assert (wb_rsp.ack === 1'b1) else begin
         $display("%s: no Wishbone ack within 20 cycles", cur_test);
         note_error();
      end
      rdat = wb_rsp.dat;   // Valid while ack is high
      @(posedge sd_clk);
      #10;
      wb_req = '0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdat);
      wb_access(1'b0, adr, '0, rdat);
   endtask

   task automatic wait_idle();
      logic [31:0] s;
      int          n;
      n = 0;
      do begin
         wb_read(reg_status, s);
         n++;
      end while (s[0] && n < 50);
      assert (!s[0]) else begin
         $display("%s: transfer still busy after 50 status polls", cur_test);
         note_error();
      end
   endtask

   task automatic push_tx(input int first, input int n);
      int i;
      for (i = first; i < first + n; i++) begin
         wb_write(reg_data, tx_words[i]);
      end
   endtask

   // Collects one write frame, returns at the first negedge with dat_oe low
   task automatic capture_frame();
      int n;
      cap_q.delete();
      n = 0;
      do begin
         @(negedge sd_clk);
         n++;
      end while (dat_oe !== 1'b1 && n < 200);
      assert (dat_oe === 1'b1) else begin
         $display("%s: no write frame started within 200 cycles", cur_test);
         note_error();
      end
      while (dat_oe === 1'b1) begin
         cap_q.push_back(dat_out);
         @(negedge sd_clk);
      end
   endtask

   // Card busy on DAT0, the host must stay off the lines meanwhile
   task automatic card_hold(input int cycles);
      int oe_cnt;
      oe_cnt = 0;
      @(posedge sd_clk);
      #10 dat_in[0] = 1'b0;
      repeat (cycles) begin
         @(negedge sd_clk);
         if (dat_oe !== 1'b0) oe_cnt++;
      end
      @(posedge sd_clk);
      #10 dat_in[0] = 1'b1;
      check_val("dat_oe cycles during card busy", 32'd0, oe_cnt);
   endtask

   // Start nibble, data MSB nibble first, CRC per line MSB first, end F
   task automatic build_frame(input int first, input int nwords);
      logic [15:0] crc [4];
      logic [3:0]  nib;
      int          w;
      int          i;
      int          k;
      exp_q.delete();
      for (k = 0; k < 4; k++) crc[k] = '0;
      exp_q.push_back(4'h0);
      for (w = first; w < first + nwords; w++) begin
         for (i = 7; i >= 0; i--) begin
            nib = tx_words[w][4*i +: 4];
            exp_q.push_back(nib);
            for (k = 0; k < 4; k++) crc[k] = crc_step(crc[k], nib[k]);
         end
      end
      for (i = 15; i >= 0; i--) begin
         for (k = 0; k < 4; k++) nib[k] = crc[k][i];
         exp_q.push_back(nib);
      end
      exp_q.push_back(4'hF);
   endtask

   task automatic compare_frame();
      int i;
      check_val("frame length", exp_q.size(), cap_q.size());
      for (i = 0; i < exp_q.size() && i < cap_q.size(); i++) begin
         if (cap_q[i] !== exp_q[i]) begin
            check_val($sformatf("frame nibble %0d", i), 32'(exp_q[i]), 32'(cap_q[i]));
            break;      // First mismatch is enough
         end
      end
   endtask

   // Card side of a read frame, flip_line >= 0 corrupts the first CRC bit
   task automatic card_send_block(input int first, input int nwords, input int flip_line);
      logic [15:0] crc [4];
      logic [3:0]  nib;
      int          w;
      int          i;
      int          k;
      for (k = 0; k < 4; k++) crc[k] = '0;
      @(posedge sd_clk);
      #10 dat_in = 4'h0;
      for (w = first; w < first + nwords; w++) begin
         for (i = 7; i >= 0; i--) begin
            nib = rx_words[w][4*i +: 4];
            for (k = 0; k < 4; k++) crc[k] = crc_step(crc[k], nib[k]);
            @(posedge sd_clk);
            #10 dat_in = nib;
         end
      end
      for (i = 15; i >= 0; i--) begin
         for (k = 0; k < 4; k++) nib[k] = crc[k][i];
         if (i == 15 && flip_line >= 0) nib[flip_line] = ~nib[flip_line];
         @(posedge sd_clk);
         #10 dat_in = nib;
      end
      @(posedge sd_clk);
      #10 dat_in = 4'hF;         // End nibble, then the lines idle high
      repeat (2) @(posedge sd_clk);
   endtask

   task automatic read_rx(input int first, input int n);
      logic [31:0] rd;
      int          i;
      for (i = first; i < first + n; i++) begin
         wb_read(reg_data, rd);
         check_val($sformatf("rx word %0d", i), rx_words[i], rd);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic regs_after_reset();
      logic [31:0] rd;
      start_test("regs after reset");
      wb_read(reg_status, rd);
      check_val("status", 32'd0, rd);
      @(negedge sd_clk);
      check_val("dat_oe", 32'd0, 32'(dat_oe));
      wb_write(reg_blksz, 32'h1FC);
      wb_write(reg_blkcnt, 32'hA5C3);
      wb_read(reg_blksz, rd);
      check_val("blksz", 32'h1FC, rd);
      wb_read(reg_blkcnt, rd);
      check_val("blkcnt", 32'hA5C3, rd);
      end_test();
   endtask

   task automatic single_block_write();
      logic [31:0] rd;
      start_test("single block write");
      push_tx(0, 4);
      wb_write(reg_blksz, 32'd16);
      wb_write(reg_blkcnt, 32'd1);
      wb_write(reg_ctrl, 32'h1);
      capture_frame();
      card_hold(5);
      build_frame(0, 4);
      compare_frame();
      wait_idle();
      wb_read(reg_status, rd);
      check_val("status", st_done, rd);
      end_test();
   endtask

   task automatic busy_between_blocks();
      logic [31:0] rd;
      start_test("busy between blocks");
      push_tx(4, 8);
      wb_write(reg_blkcnt, 32'd2);
      wb_write(reg_ctrl, 32'h1);
      capture_frame();
      build_frame(4, 4);
      compare_frame();
      fork
         card_hold(20);
         begin
            repeat (4) @(posedge sd_clk);
            wb_read(reg_status, rd);
            check_val("status during card busy", st_busy | st_card_busy, rd);
         end
      join
      capture_frame();
      card_hold(2);
      build_frame(8, 4);
      compare_frame();
      wait_idle();
      wb_read(reg_status, rd);
      check_val("status", st_done, rd);
      end_test();
   endtask

   task automatic two_block_read();
      logic [31:0] rd;
      start_test("two block read");
      wb_write(reg_blksz, 32'd8);
      wb_write(reg_blkcnt, 32'd2);
      wb_write(reg_ctrl, 32'h2);
      card_send_block(0, 2, -1);
      card_send_block(2, 2, -1);
      wait_idle();
      wb_read(reg_status, rd);
      check_val("status", st_done, rd);
      read_rx(0, 4);
      end_test();
   endtask

   task automatic read_crc_error();
      logic [31:0] rd;
      start_test("read crc error");
      wb_write(reg_blkcnt, 32'd1);
      wb_write(reg_ctrl, 32'h2);
      card_send_block(4, 2, 2);
      wait_idle();
      wb_read(reg_status, rd);
      check_val("status", st_done | st_crc_err, rd);
      read_rx(4, 2);             // Leaves the receive FIFO empty
      end_test();
   endtask

   task automatic rx_overflow();
      logic [31:0] rd;
      start_test("rx overflow");
      wb_write(reg_blksz, 32'd512);
      wb_write(reg_blkcnt, 32'd2);
      wb_write(reg_ctrl, 32'h2);
      card_send_block(0, 128, -1);
      card_send_block(128, 128, -1);
      wait_idle();
      wb_read(reg_status, rd);
      check_val("status", st_done | st_overflow, rd);
      read_rx(0, 128);
      wb_read(reg_data, rd);
      check_val("read of empty FIFO", 32'd0, rd);
      end_test();
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int i;
      wb_req       = '0;
      dat_in       = 4'hF;        // Pull-ups on the DAT lines
      rst_L        = 1'b0;
      err_cnt      = 0;
      tests_run    = 0;
      tests_failed = 0;
      lfsr         = 32'd31;
      for (i = 0; i < 256; i++) tx_words[i] = next_word();
      for (i = 0; i < 256; i++) rx_words[i] = next_word();
      repeat (2) @(posedge sd_clk);
      #10 rst_L = 1'b1;

      regs_after_reset();
      single_block_write();
      busy_between_blocks();
      two_block_read();
      read_crc_error();
      rx_overflow();

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: filelist.f
sd_pkg.sv
sd_crc16.sv
sd_fifo.sv
sd_dat_phys.sv
sd_wb_regs.sv
sd_dat_top.sv
tb_sd_dat.sv

// File: run_sim.sh
#!/bin/sh
# Build the DAT path testbench with Verilator, run it, check the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sd_dat -Mdir obj_dir \
   -f filelist.f > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_sd_dat > sim.log 2>&1
grep -q "Finished with no errors" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
